// File: src.f
+incdir+verilog
verilog/slave_agent_pkg.sv
verilog/sync_fifo.sv
verilog/cmd_decoder.sv
verilog/resp_assembler.sv
verilog/slave_agent_top.sv
tb/avalon_slave_model.sv
tb/tb_slave_agent.sv

// File: tb/tb_slave_agent.sv
`timescale 1ns/1ps
`include "slave_agent_defines.svh"

module tb_slave_agent;

  import slave_agent_pkg::*;

  // 60 commands need a few hundred cycles
  // limit set well above that
  localparam int NUM_CMDS    = 60;
  localparam int CYCLE_LIMIT = 2000;

  logic  clk;
  logic  rst;
  logic  cp_valid;
  pkt_t  cp_data;
  logic  cp_ready;
  addr_t m0_address;
  be_t   m0_byteenable;
  data_t m0_writedata;
  logic  m0_read;
  logic  m0_write;
  data_t m0_readdata;
  logic  m0_readdatavalid;
  logic  m0_waitrequest;
  logic  rp_valid;
  pkt_t  rp_data;
  logic  rp_ready;

  // --------------------------------------------------
  // scoreboard state
  // --------------------------------------------------
  data_t shadow [256];
  pkt_t  exp_q [$];
  // responses owed by the DUT
  // tracks the token fifo fill
  int    outstanding = 0;
  int    cycle_count = 0;
  // percent of cycles with rp_ready high
  int    ready_pct   = 60;
  logic  held_valid  = 1'b0;
  logic  held_ready  = 1'b0;
  pkt_t  held_data;

  slave_agent_top u_dut (.*);

  avalon_slave_model u_mem (
    .clk           (clk),
    .rst           (rst),
    .address       (m0_address),
    .byteenable    (m0_byteenable),
    .writedata     (m0_writedata),
    .read          (m0_read),
    .write         (m0_write),
    .waitrequest   (m0_waitrequest),
    .readdata      (m0_readdata),
    .readdatavalid (m0_readdatavalid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) abort_run("timeout, the run did not finish in time");
  end

  // random response back-pressure
  always @(posedge clk) begin
    #1;
    rp_ready = !rst && ($urandom_range(0, 99) < ready_pct);
  end

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "check failed");
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  function automatic pkt_t next_cmd(input int idx);
    pkt_t       cmd;
    logic [1:0] kind;
    addr_t      addr;
    be_t        be;
    // kind 0 read, 1 non-posted write, 2 posted write
    kind = 2'($urandom_range(0, 2));
    addr = addr_t'($urandom_range(0, 15));
    be   = ($urandom_range(0, 4) == 0) ? '0 : be_t'($urandom_range(1, 15));
    // opening sequence of read, zero-be read, write and posted write
    // then addresses 5 and 6 read back
    case (idx)
      0: {kind, addr, be} = {2'd0, 16'd3, 4'hf};
      1: {kind, addr, be} = {2'd0, 16'd4, 4'h0};
      2: {kind, addr, be} = {2'd1, 16'd5, 4'h5};
      3: {kind, addr, be} = {2'd2, 16'd6, 4'hc};
      4: {kind, addr, be} = {2'd0, 16'd5, 4'hf};
      5: {kind, addr, be} = {2'd0, 16'd6, 4'h1};
      default: ;
    endcase
    cmd = '0;
    cmd[`DATA_H:`DATA_L]       = $urandom;
    cmd[`ADDR_H:`ADDR_L]       = addr;
    cmd[`BYTEEN_H:`BYTEEN_L]   = be;
    cmd[`TRANS_READ]           = (kind == 2'd0);
    cmd[`TRANS_WRITE]          = (kind != 2'd0);
    cmd[`TRANS_POSTED]         = (kind == 2'd2);
    cmd[`SRC_ID_H:`SRC_ID_L]   = id_t'($urandom_range(0, 7));
    cmd[`DEST_ID_H:`DEST_ID_L] = id_t'($urandom_range(0, 7));
    return cmd;
  endfunction

  // starts 1 ns after an edge
  // returns 1 ns after the accepting edge
  task automatic send_cmd(input pkt_t cmd);
    cp_valid = 1'b1;
    cp_data  = cmd;
    @(posedge clk);
    while (!cp_ready) @(posedge clk);
    #1;
  endtask

  // shadow memory update and expected response for one accepted command
  task automatic record_cmd(input pkt_t cmd);
    logic [7:0] idx;
    be_t        be;
    pkt_t       resp;
    idx  = cmd[`ADDR_L +: 8];
    be   = cmd[`BYTEEN_H:`BYTEEN_L];
    // fields copied, ids swapped, data zero unless real readdata
    resp = cmd;
    resp[`SRC_ID_H:`SRC_ID_L]   = cmd[`DEST_ID_H:`DEST_ID_L];
    resp[`DEST_ID_H:`DEST_ID_L] = cmd[`SRC_ID_H:`SRC_ID_L];
    resp[`DATA_H:`DATA_L]       = '0;
    if (cmd[`TRANS_WRITE]) begin
      for (int b = 0; b < `BE_W; b++) begin
        if (be[b]) shadow[idx][8*b +: 8] = cmd[`DATA_L + 8*b +: 8];
      end
      if (!cmd[`TRANS_POSTED]) begin
        exp_q.push_back(resp);
        outstanding++;
      end
    end else if (cmd[`TRANS_READ]) begin
      if (be != '0) resp[`DATA_H:`DATA_L] = shadow[idx];
      exp_q.push_back(resp);
      outstanding++;
    end
  endtask

  // --------------------------------------------------
  // checks sampled at the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    logic fire;
    logic live;
    pkt_t expected;
    fire = cp_valid && cp_ready;
    live = (cp_data[`BYTEEN_H:`BYTEEN_L] != '0);
    if (!rst) begin
      assert (cp_valid || (!m0_read && !m0_write))
        else flag_mismatch("slave strobe with cp_valid low");
      // one slave access per accepted command with live byte enables
      assert ((m0_read && !m0_waitrequest) == (fire && cp_data[`TRANS_READ] && live))
        else flag_mismatch("slave read does not match accepted read");
      assert ((m0_write && !m0_waitrequest) == (fire && cp_data[`TRANS_WRITE] && live))
        else flag_mismatch("slave write does not match accepted write");
      // slave fields follow the command packet
      if (m0_read || m0_write) begin
        assert (m0_address == cp_data[`ADDR_H:`ADDR_L] &&
                m0_byteenable == cp_data[`BYTEEN_H:`BYTEEN_L])
          else flag_mismatch($sformatf("slave address %h byteenable %h differ from command",
                                       m0_address, m0_byteenable));
      end
      if (m0_write) begin
        assert (m0_writedata == cp_data[`DATA_H:`DATA_L])
          else flag_mismatch($sformatf("slave writedata %h differs from command",
                                       m0_writedata));
      end
      assert (outstanding < `RESP_DEPTH || !cp_ready)
        else flag_mismatch($sformatf("cp_ready high with %0d outstanding", outstanding));
      if (held_valid && !held_ready) begin
        assert (rp_valid && rp_data === held_data)
          else flag_mismatch("response dropped or changed before transfer");
      end
      if (rp_valid && rp_ready) begin
        if (exp_q.size() == 0) abort_run("response transferred with none outstanding");
        expected = exp_q.pop_front();
        assert (rp_data === expected)
          else flag_mismatch($sformatf("rp_data %h expected %h", rp_data, expected));
        outstanding--;
      end
      if (fire) record_cmd(cp_data);
    end
    held_valid = rp_valid && !rst;
    held_ready = rp_ready;
    held_data  = rp_data;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    pkt_t       cmd;
    logic [7:0] a;
    void'($urandom(7496));
    rst      = 1'b1;
    cp_valid = 1'b0;
    cp_data  = '0;
    rp_ready = 1'b0;
    // same image in the slave model and the shadow copy
    for (int i = 0; i < 256; i++) begin
      a            = 8'(i);
      shadow[i]    = {a ^ 8'hc3, a + 8'h29, ~a, a};
      u_mem.mem[i] = {a ^ 8'hc3, a + 8'h29, ~a, a};
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    assert (!rp_valid && !m0_read && !m0_write)
      else flag_mismatch("outputs active after reset");
    #1;
    for (int i = 0; i < NUM_CMDS; i++) begin
      // long response stall in the middle fills the token fifo
      ready_pct = (i >= 20 && i < 40) ? 15 : 60;
      cmd = next_cmd(i);
      send_cmd(cmd);
      if ($urandom_range(0, 3) == 0) begin
        cp_valid = 1'b0;
        @(posedge clk);
        #1;
      end
    end
    cp_valid  = 1'b0;
    ready_pct = 100;
    // drain
    while (outstanding != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    if (!rp_valid) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("responses left over at the end of the run");
    end
  end

endmodule

// File: tb/avalon_slave_model.sv
`timescale 1ns/1ps

module avalon_slave_model (
  input  logic                   clk,
  input  logic                   rst,
  input  slave_agent_pkg::addr_t address,
  input  slave_agent_pkg::be_t   byteenable,
  input  slave_agent_pkg::data_t writedata,
  input  logic                   read,
  input  logic                   write,
  output logic                   waitrequest,
  output slave_agent_pkg::data_t readdata,
  output logic                   readdatavalid
);

  import slave_agent_pkg::*;

  // word memory, image loaded from the testbench
  data_t mem [256];

  // readdata waiting to return, with the cycle it is due
  data_t rd_q [$];
  int    due_q [$];
  int    cycle    = 0;
  int    last_due = 0;

  initial begin
    waitrequest   = 1'b1;
    readdata      = '0;
    readdatavalid = 1'b0;
  end

  always @(posedge clk) begin
    data_t word;
    logic  rdv;
    int    due;
    word = readdata;
    rdv  = 1'b0;
    cycle++;
    if (rst) begin
      rd_q.delete();
      due_q.delete();
    end else begin
      // oldest read returns first, one word per cycle
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        rdv  = 1'b1;
        word = rd_q.pop_front();
        void'(due_q.pop_front());
      end
      if (read && !waitrequest) begin
        // latency 1 to 3 cycles, never overtaking an earlier read
        due = cycle + $urandom_range(1, 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rd_q.push_back(mem[address[7:0]]);
        due_q.push_back(due);
      end
      // byte lane writes
      if (write && !waitrequest) begin
        for (int b = 0; b < 4; b++) begin
          if (byteenable[b]) mem[address[7:0]][8*b +: 8] = writedata[8*b +: 8];
        end
      end
    end
    #1;
    readdata      = word;
    readdatavalid = rdv;
    // stall roughly one cycle in three
    waitrequest   = ($urandom_range(0, 2) == 0);
  end

endmodule

// File: verilog/slave_agent_top.sv
`timescale 1ns/1ps
`include "slave_agent_defines.svh"

module slave_agent_top (
  input  logic                   clk,
  input  logic                   rst,

  // command packet sink
  input  logic                   cp_valid,
  input  slave_agent_pkg::pkt_t  cp_data,
  output logic                   cp_ready,

  // slave bus
  output slave_agent_pkg::addr_t m0_address,
  output slave_agent_pkg::be_t   m0_byteenable,
  output slave_agent_pkg::data_t m0_writedata,
  output logic                   m0_read,
  output logic                   m0_write,
  input  slave_agent_pkg::data_t m0_readdata,
  input  logic                   m0_readdatavalid,
  input  logic                   m0_waitrequest,

  // response packet source
  output logic                   rp_valid,
  output slave_agent_pkg::pkt_t  rp_data,
  input  logic                   rp_ready
);

  import slave_agent_pkg::*;

  // token path
  logic   token_full;
  logic   token_push;
  token_t token_in;
  logic   token_valid;
  token_t token_head;
  logic   token_pop;

  // readdata path
  logic   rdata_valid;
  data_t  rdata_head;
  logic   rdata_pop;

  // --------------------------------------------------
  // command side
  // --------------------------------------------------
  cmd_decoder u_cmd (
    .cp_valid       (cp_valid),
    .cp_data        (cp_data),
    .cp_ready       (cp_ready),
    .m0_address     (m0_address),
    .m0_byteenable  (m0_byteenable),
    .m0_writedata   (m0_writedata),
    .m0_read        (m0_read),
    .m0_write       (m0_write),
    .m0_waitrequest (m0_waitrequest),
    .token_full     (token_full),
    .token_push     (token_push),
    .token_data     (token_in)
  );

  // --------------------------------------------------
  // buffering between the two sides
  // --------------------------------------------------
  // one token per outstanding response
  sync_fifo #(
    .WIDTH ($bits(token_t)),
    .DEPTH (`RESP_DEPTH)
  ) u_token_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (token_push),
    .push_data (token_in),
    .full      (token_full),
    .pop       (token_pop),
    .pop_data  (token_head),
    .valid     (token_valid)
  );

  // same depth as the token fifo
  // so reads are throttled before this one can fill
  sync_fifo #(
    .WIDTH (`DATA_W),
    .DEPTH (`RESP_DEPTH)
  ) u_rdata_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (m0_readdatavalid),
    .push_data (m0_readdata),
    .full      (),
    .pop       (rdata_pop),
    .pop_data  (rdata_head),
    .valid     (rdata_valid)
  );

  // --------------------------------------------------
  // response side
  // --------------------------------------------------
  resp_assembler u_resp (
    .token_valid (token_valid),
    .token_data  (token_head),
    .token_pop   (token_pop),
    .rdata_valid (rdata_valid),
    .rdata       (rdata_head),
    .rdata_pop   (rdata_pop),
    .rp_valid    (rp_valid),
    .rp_data     (rp_data),
    .rp_ready    (rp_ready)
  );

endmodule

// File: verilog/resp_assembler.sv
`timescale 1ns/1ps
`include "slave_agent_defines.svh"

module resp_assembler (
  // token fifo read side
  input  logic                    token_valid,
  input  slave_agent_pkg::token_t token_data,
  output logic                    token_pop,
  // readdata fifo read side
  input  logic                    rdata_valid,
  input  slave_agent_pkg::data_t  rdata,
  output logic                    rdata_pop,
  // response packet source
  output logic                    rp_valid,
  output slave_agent_pkg::pkt_t   rp_data,
  input  logic                    rp_ready
);

  import slave_agent_pkg::*;

  // --------------------------------------------------
  // token fields
  // --------------------------------------------------
  addr_t tok_addr;
  be_t   tok_byteen;
  id_t   tok_src;
  id_t   tok_dest;
  logic  tok_read;
  logic  tok_write;
  logic  tok_posted;
  logic  tok_synth;
  data_t resp_word;
  logic  resp_fire;

  assign tok_synth  = token_data[`PKT_W];
  assign tok_addr   = token_data[`ADDR_H:`ADDR_L];
  assign tok_byteen = token_data[`BYTEEN_H:`BYTEEN_L];
  assign tok_read   = token_data[`TRANS_READ];
  assign tok_write  = token_data[`TRANS_WRITE];
  assign tok_posted = token_data[`TRANS_POSTED];
  assign tok_src    = token_data[`SRC_ID_H:`SRC_ID_L];
  assign tok_dest   = token_data[`DEST_ID_H:`DEST_ID_L];

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  // a real read waits for its readdata
  // synthesized responses go as soon as the token shows up
  assign rp_valid  = token_valid & (tok_synth | rdata_valid);
  assign resp_fire = rp_valid & rp_ready;

  assign token_pop = resp_fire;
  // readdata only consumed by the token that owns it
  assign rdata_pop = resp_fire & ~tok_synth;

  // --------------------------------------------------
  // packet assembly
  // --------------------------------------------------
  // synthesized responses carry zero data
  assign resp_word = tok_synth ? '0 : rdata;

  always_comb begin
    rp_data = '0;
    rp_data[`DATA_H:`DATA_L]       = resp_word;
    rp_data[`ADDR_H:`ADDR_L]       = tok_addr;
    rp_data[`BYTEEN_H:`BYTEEN_L]   = tok_byteen;
    rp_data[`TRANS_READ]           = tok_read;
    rp_data[`TRANS_WRITE]          = tok_write;
    rp_data[`TRANS_POSTED]         = tok_posted;
    // ids swapped so the response routes back to the requester
    rp_data[`SRC_ID_H:`SRC_ID_L]   = tok_dest;
    rp_data[`DEST_ID_H:`DEST_ID_L] = tok_src;
  end

endmodule

// File: verilog/cmd_decoder.sv
`timescale 1ns/1ps
`include "slave_agent_defines.svh"

module cmd_decoder (
  // command packet sink
  input  logic                    cp_valid,
  input  slave_agent_pkg::pkt_t   cp_data,
  output logic                    cp_ready,
  // slave bus master side
  output slave_agent_pkg::addr_t  m0_address,
  output slave_agent_pkg::be_t    m0_byteenable,
  output slave_agent_pkg::data_t  m0_writedata,
  output logic                    m0_read,
  output logic                    m0_write,
  input  logic                    m0_waitrequest,
  // response token fifo write side
  input  logic                    token_full,
  output logic                    token_push,
  output slave_agent_pkg::token_t token_data
);

  import slave_agent_pkg::*;

  // --------------------------------------------------
  // command fields
  // --------------------------------------------------
  data_t cmd_data;
  addr_t cmd_addr;
  be_t   cmd_byteen;
  id_t   cmd_src;
  id_t   cmd_dest;
  logic  cmd_read;
  logic  cmd_write;
  logic  cmd_posted;
  logic  byteen_asserted;
  logic  need_response;
  logic  synthesize;

  assign cmd_data   = cp_data[`DATA_H:`DATA_L];
  assign cmd_addr   = cp_data[`ADDR_H:`ADDR_L];
  assign cmd_byteen = cp_data[`BYTEEN_H:`BYTEEN_L];
  assign cmd_read   = cp_data[`TRANS_READ];
  assign cmd_write  = cp_data[`TRANS_WRITE];
  assign cmd_posted = cp_data[`TRANS_POSTED];
  assign cmd_src    = cp_data[`SRC_ID_H:`SRC_ID_L];
  assign cmd_dest   = cp_data[`DEST_ID_H:`DEST_ID_L];

  // all-zero byte enables never reach the slave
  assign byteen_asserted = |cmd_byteen;

  // --------------------------------------------------
  // slave strobes and back-pressure
  // --------------------------------------------------
  assign m0_address    = cmd_addr;
  assign m0_byteenable = cmd_byteen;
  assign m0_writedata  = cmd_data;

  // strobes held off while the token fifo is full
  // otherwise the slave could take a command that cp_ready refuses
  assign m0_read  = cp_valid & cmd_read & byteen_asserted & ~token_full;
  assign m0_write = cp_valid & cmd_write & byteen_asserted & ~token_full;

  // suppressed commands complete without waiting on the slave
  assign cp_ready = ~token_full & (~m0_waitrequest | ~byteen_asserted);

  // --------------------------------------------------
  // response tokens
  // --------------------------------------------------
  // reads and non-posted writes owe a response
  assign need_response = cmd_read | (cmd_write & ~cmd_posted);
  assign token_push    = cp_valid & cp_ready & need_response;

  // no readdata will come back for these
  assign synthesize = (cmd_read & ~byteen_asserted) | (cmd_write & ~cmd_posted);

  always_comb begin
    // data field and reserved bits stay zero
    token_data = '0;
    token_data[`PKT_W]                 = synthesize;
    token_data[`ADDR_H:`ADDR_L]        = cmd_addr;
    token_data[`BYTEEN_H:`BYTEEN_L]    = cmd_byteen;
    token_data[`TRANS_READ]            = cmd_read;
    token_data[`TRANS_WRITE]           = cmd_write;
    token_data[`TRANS_POSTED]          = cmd_posted;
    token_data[`SRC_ID_H:`SRC_ID_L]    = cmd_src;
    token_data[`DEST_ID_H:`DEST_ID_L]  = cmd_dest;
  end

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             valid
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_next;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH so non power of two depths work
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign valid   = (count != '0);
  // push when full and pop when empty are dropped
  assign do_push = push & ~full;
  assign do_pop  = pop & valid;
  assign rd_next = do_pop ? ptr_inc(rd_ptr) : rd_ptr;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      rd_ptr <= rd_next;
      count  <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // storage and registered head
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
    // bypass when the pushed word becomes the new head
    if (do_push && (count - CNT_W'(do_pop)) == '0) begin
      pop_data <= push_data;
    end else begin
      pop_data <= mem[rd_next];
    end
  end

endmodule

// File: verilog/slave_agent_pkg.sv
`include "slave_agent_defines.svh"

package slave_agent_pkg;

  // --------------------------------------------------
  // packet level vectors
  // --------------------------------------------------

  // one full command or response beat
  typedef logic [`PKT_W-1:0] pkt_t;

  // command packet with data zeroed
  // top bit set when the response is synthesized locally
  typedef logic [`PKT_W:0] token_t;

  // --------------------------------------------------
  // slave bus fields
  // --------------------------------------------------

  // writedata / readdata word
  typedef logic [`DATA_W-1:0] data_t;

  // word address toward the slave
  typedef logic [`ADDR_W-1:0] addr_t;

  // one enable per byte lane
  typedef logic [`BE_W-1:0] be_t;

  // source or destination id
  typedef logic [`ID_W-1:0] id_t;

endpackage

// File: verilog/slave_agent_defines.svh
`ifndef SLAVE_AGENT_DEFINES_SVH
`define SLAVE_AGENT_DEFINES_SVH

// --------------------------------------------------
// packet layout (single beat, command and response)
// --------------------------------------------------
`define PKT_W        64

// write data on commands, read data on responses
`define DATA_H       31
`define DATA_L       0
`define ADDR_H       47
`define ADDR_L       32
`define BYTEEN_H     51
`define BYTEEN_L     48

// transaction type bits
`define TRANS_READ   52
`define TRANS_WRITE  53
`define TRANS_POSTED 54

// routing ids, bits 63..61 stay reserved
`define SRC_ID_H     57
`define SRC_ID_L     55
`define DEST_ID_H    60
`define DEST_ID_L    58

// --------------------------------------------------
// field widths and buffering
// --------------------------------------------------
`define DATA_W       32
`define ADDR_W       16
`define BE_W         4
`define ID_W         3
// entries in the token fifo and in the readdata fifo
`define RESP_DEPTH   4

`endif
